/* rtl/mac_pkg.sv */
package mac_pkg;

  // widths with a meaning of their own
  typedef logic [7:0]  byte_t;
  typedef logic [47:0] mac_addr_t;   // msb sent first
  typedef logic [15:0] ethertype_t;
  typedef logic [6:0]  frame_len_t;  // payload bytes incl. pad
  typedef logic [31:0] crc_t;

  // frame layout
  localparam int    PREAMBLE_LEN  = 7;
  localparam byte_t PREAMBLE_BYTE = 8'h55;
  localparam byte_t SFD_BYTE      = 8'hD5;
  localparam int    ADDR_LEN      = 6;
  localparam int    TYPE_LEN      = 2;
  localparam int    HDR_LEN       = 14;
  localparam int    MIN_PAYLOAD   = 46;
  localparam int    FCS_LEN       = 4;

  localparam int    FIFO_AW       = 6;  // 64 byte tx buffer

  // reflected crc-32
  localparam crc_t  CRC_POLY      = 32'hEDB88320;
  localparam crc_t  CRC_RESIDUE   = 32'hDEBB20E3;  // register after data + good fcs

  typedef enum logic [3:0] {
    TX_IDLE,
    TX_PREAMBLE,
    TX_SFD,
    TX_DST,
    TX_SRC,
    TX_TYPE,
    TX_PAYLOAD,
    TX_PAD,
    TX_FCS
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_HUNT,
    RX_HEADER,
    RX_PAYLOAD,
    RX_DONE
  } rx_state_t;

endpackage

/* rtl/crc32.sv */
`timescale 1ns/1ps

module crc32
  import mac_pkg::*;
(
  input  logic  clk,
  input  logic  fsm_rst,
  input  logic  clr,
  input  byte_t dat,
  input  logic  en,
  output crc_t  crc,
  output logic  ok
);

  // one byte through the reflected lfsr, lsb first
  function automatic crc_t crc_step(input crc_t cur, input byte_t d);
    crc_t r;
    r = cur ^ {24'h0, d};
    for (int i = 0; i < 8; i++) begin
      if (r[0]) begin
        r = (r >> 1) ^ CRC_POLY;
      end else begin
        r = r >> 1;
      end
    end
    return r;
  endfunction

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      crc <= '1;
    end else if (clr) begin
      crc <= '1;  // seed for a new frame
    end else if (en) begin
      crc <= crc_step(crc, dat);
    end
  end

  // residue check, only meaningful right after the fcs went in
  assign ok = (crc == CRC_RESIDUE);

endmodule

/* rtl/tx_fifo.sv */
`timescale 1ns/1ps

module tx_fifo
  import mac_pkg::*;
(
  input  logic  clk,
  input  logic  fsm_rst,
  input  byte_t wr_dat,
  input  logic  wr,
  input  logic  rd,
  output byte_t rd_dat,
  output logic  empty,
  output logic  full
);

  localparam int DEPTH = 2 ** FIFO_AW;

  byte_t            mem [DEPTH];
  logic [FIFO_AW:0] wr_ptr;  // extra bit tells full from empty
  logic [FIFO_AW:0] rd_ptr;
  logic [FIFO_AW:0] count;
  logic             do_wr;
  logic             do_rd;

  assign count = wr_ptr - rd_ptr;
  assign empty = (count == '0);
  assign full  = count[FIFO_AW];

  assign do_wr = wr && !full;   // writes into a full buffer are lost
  assign do_rd = rd && !empty;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr[FIFO_AW-1:0]] <= wr_dat;
    end
    if (do_rd) begin
      rd_dat <= mem[rd_ptr[FIFO_AW-1:0]];  // valid one cycle after rd
    end
  end

endmodule

/* rtl/tx_byte_counter.sv */
`timescale 1ns/1ps

module tx_byte_counter
  import mac_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       load,
  input  frame_len_t load_len,
  input  logic       step,
  input  logic       pay_clr,
  output logic       last,
  output logic       min_done
);

  frame_len_t fld_cnt;  // bytes left in the current field
  frame_len_t pay_cnt;  // payload + pad bytes already sent

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      fld_cnt <= '0;
      pay_cnt <= '0;
    end else begin
      if (load) begin
        fld_cnt <= load_len;
      end else if (step && fld_cnt != '0) begin
        fld_cnt <= fld_cnt - 1'b1;
      end
      if (pay_clr) begin
        pay_cnt <= '0;
      end else if (step && !min_done) begin
        pay_cnt <= pay_cnt + 1'b1;  // sticks once minimum is hit
      end
    end
  end

  assign last = (fld_cnt == frame_len_t'(1));
  // high while the 46th payload byte is being stepped, and after
  assign min_done = (pay_cnt == frame_len_t'(MIN_PAYLOAD - 1));

endmodule

/* rtl/tx_framer_fsm.sv */
`timescale 1ns/1ps

module tx_framer_fsm
  import mac_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  logic       avl,
  input  mac_addr_t  dst,
  input  ethertype_t ethertype,
  input  mac_addr_t  src,
  input  byte_t      fifo_dat,
  input  logic       fifo_empty,
  input  logic       cnt_last,
  input  logic       cnt_min_done,
  input  crc_t       crc,
  output logic       fifo_rd,
  output logic       cnt_load,
  output frame_len_t cnt_len,
  output logic       cnt_step,
  output logic       cnt_pay_clr,
  output logic       crc_clr,
  output logic       crc_en,
  output byte_t      crc_dat,
  output byte_t      phy_dat,
  output logic       phy_val,
  output logic       busy,
  output logic       done
);

  tx_state_t  state;
  tx_state_t  state_nxt;
  mac_addr_t  dst_sr;
  mac_addr_t  src_sr;
  ethertype_t type_sr;
  logic [1:0] fcs_idx;    // fcs byte, lsb first
  logic       avl_taken;  // one frame per avl high period
  logic       start;
  logic       type_end;
  byte_t      tx_byte;
  crc_t       fcs;

  assign start    = (state == TX_IDLE) && avl && !avl_taken;
  assign type_end = (state == TX_TYPE) && cnt_last;
  assign fcs      = ~crc;

  always_comb begin
    state_nxt = state;
    case (state)
      TX_IDLE:     if (start) state_nxt = TX_PREAMBLE;
      TX_PREAMBLE: if (cnt_last) state_nxt = TX_SFD;
      TX_SFD:      state_nxt = TX_DST;
      TX_DST:      if (cnt_last) state_nxt = TX_SRC;
      TX_SRC:      if (cnt_last) state_nxt = TX_TYPE;
      TX_TYPE: begin
        if (cnt_last) begin
          state_nxt = fifo_empty ? TX_PAD : TX_PAYLOAD;  // empty buffer sends pad only
        end
      end
      TX_PAYLOAD: begin
        if (fifo_empty) begin
          state_nxt = cnt_min_done ? TX_FCS : TX_PAD;
        end
      end
      TX_PAD:      if (cnt_min_done) state_nxt = TX_FCS;
      TX_FCS:      if (cnt_last) state_nxt = TX_IDLE;
      default:     state_nxt = TX_IDLE;
    endcase
  end

  // field counter gets the length of each field on entry
  always_comb begin
    case (state_nxt)
      TX_PREAMBLE: cnt_len = frame_len_t'(PREAMBLE_LEN);
      TX_DST:      cnt_len = frame_len_t'(ADDR_LEN);
      TX_SRC:      cnt_len = frame_len_t'(ADDR_LEN);
      TX_TYPE:     cnt_len = frame_len_t'(TYPE_LEN);
      TX_FCS:      cnt_len = frame_len_t'(FCS_LEN);
      default:     cnt_len = '0;
    endcase
  end

  assign cnt_load    = (state_nxt != state) && (cnt_len != '0);
  assign cnt_step    = (state != TX_IDLE) && (state != TX_SFD);
  assign cnt_pay_clr = type_end;

  // prefetch so the first payload byte is ready on entry
  assign fifo_rd = (type_end || state == TX_PAYLOAD) && !fifo_empty;

  always_comb begin
    case (state)
      TX_PREAMBLE: tx_byte = PREAMBLE_BYTE;
      TX_SFD:      tx_byte = SFD_BYTE;
      TX_DST:      tx_byte = dst_sr[47:40];
      TX_SRC:      tx_byte = src_sr[47:40];
      TX_TYPE:     tx_byte = type_sr[15:8];
      TX_PAYLOAD:  tx_byte = fifo_dat;
      TX_FCS:      tx_byte = fcs[8*fcs_idx +: 8];
      default:     tx_byte = '0;  // pad and idle
    endcase
  end

  assign crc_clr = start;
  assign crc_en  = (state inside {TX_DST, TX_SRC, TX_TYPE, TX_PAYLOAD, TX_PAD});
  assign crc_dat = tx_byte;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state     <= TX_IDLE;
      phy_val   <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      fcs_idx   <= '0;
      avl_taken <= 1'b0;
    end else begin
      state   <= state_nxt;
      phy_val <= (state != TX_IDLE);
      done    <= phy_val && (state == TX_IDLE);  // falling edge of the stream
      if (start) begin
        busy <= 1'b1;
      end else if (phy_val && state == TX_IDLE) begin
        busy <= 1'b0;
      end
      if (start) begin
        avl_taken <= 1'b1;
      end else if (!avl) begin
        avl_taken <= 1'b0;
      end
      fcs_idx <= (state == TX_FCS) ? fcs_idx + 1'b1 : 2'd0;
    end
  end

  always_ff @(posedge clk) begin
    phy_dat <= tx_byte;
    if (start) begin
      dst_sr  <= dst;
      src_sr  <= src;
      type_sr <= ethertype;
    end else begin
      if (state == TX_DST) dst_sr <= dst_sr << 8;
      if (state == TX_SRC) src_sr <= src_sr << 8;
      if (state == TX_TYPE) type_sr <= type_sr << 8;
    end
  end

endmodule

/* rtl/rx_parser.sv */
`timescale 1ns/1ps

module rx_parser
  import mac_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  byte_t      phy_dat,
  input  logic       phy_val,
  input  logic       crc_ok,
  output logic       crc_clr,
  output logic       crc_en,
  output byte_t      dat,
  output logic       val,
  output logic       sof,
  output logic       eof,
  output logic       err,
  output mac_addr_t  dst,
  output mac_addr_t  src,
  output ethertype_t ethertype,
  output frame_len_t len
);

  localparam int HDR_W = HDR_LEN * 8;

  rx_state_t             state;
  logic [HDR_W-1:0]      hdr_sr;   // dst | src | type once full
  byte_t [FCS_LEN-1:0]   dly;      // keeps the fcs from reaching the host
  logic [3:0]            hdr_cnt;
  logic [2:0]            fill;     // payload-phase bytes in dly
  logic                  first;
  frame_len_t            pay_cnt;
  logic                  sfd_hit;
  logic                  pop;
  logic                  in_frame;

  assign in_frame = (state == RX_HEADER) || (state == RX_PAYLOAD);
  assign sfd_hit  = (state == RX_HUNT) && phy_val && (phy_dat == SFD_BYTE);
  // oldest byte leaves only once four newer ones are behind it
  assign pop      = (state == RX_PAYLOAD) && phy_val && (fill == 3'(FCS_LEN));

  assign crc_clr = sfd_hit;
  assign crc_en  = phy_val && in_frame;

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= RX_HUNT;
      val     <= 1'b0;
      sof     <= 1'b0;
      eof     <= 1'b0;
      err     <= 1'b0;
      fill    <= '0;
      first   <= 1'b0;
      hdr_cnt <= '0;
    end else begin
      val <= pop;
      sof <= pop && first;
      eof <= 1'b0;
      err <= 1'b0;
      case (state)
        RX_HUNT: begin
          if (sfd_hit) begin
            state   <= RX_HEADER;
            hdr_cnt <= '0;
            fill    <= '0;
            first   <= 1'b1;
          end
        end
        RX_HEADER: begin
          if (!phy_val) begin
            state <= RX_DONE;
            err   <= 1'b1;  // runt, header never completed
          end else begin
            hdr_cnt <= hdr_cnt + 1'b1;
            if (hdr_cnt == 4'(HDR_LEN - 1)) state <= RX_PAYLOAD;
          end
        end
        RX_PAYLOAD: begin
          if (!phy_val) begin
            state <= RX_DONE;
            eof   <= crc_ok;
            err   <= !crc_ok;
          end else begin
            if (fill != 3'(FCS_LEN)) fill <= fill + 1'b1;
            if (pop) first <= 1'b0;
          end
        end
        default: state <= RX_HUNT;  // done lasts one cycle
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phy_val) begin
      dly <= {dly[FCS_LEN-2:0], phy_dat};
    end
    dat <= dly[FCS_LEN-1];
    if (state == RX_HEADER && phy_val) begin
      hdr_sr <= {hdr_sr[HDR_W-9:0], phy_dat};
    end
    if (sfd_hit) begin
      pay_cnt <= '0;
    end else if (pop) begin
      pay_cnt <= pay_cnt + 1'b1;
    end
    // header fields change only together with sof
    if (pop && first) begin
      dst       <= hdr_sr[HDR_W-1 -: 48];
      src       <= hdr_sr[HDR_W-49 -: 48];
      ethertype <= hdr_sr[15:0];
    end
    if (state == RX_PAYLOAD && !phy_val && crc_ok) begin
      len <= pay_cnt;
    end
  end

endmodule

/* rtl/mac_top.sv */
`timescale 1ns/1ps

module mac_top
  import mac_pkg::*;
(
  input  logic       clk,
  input  logic       fsm_rst,
  input  mac_addr_t  dev_mac_addr,
  // transmit host side
  input  byte_t      tx_wr_dat,
  input  logic       tx_wr,
  input  logic       tx_avl,
  input  mac_addr_t  tx_dst,
  input  ethertype_t tx_type,
  output logic       tx_full,
  output logic       tx_busy,
  output logic       tx_done,
  // phy stream
  output byte_t      phy_tx_dat,
  output logic       phy_tx_val,
  input  byte_t      phy_rx_dat,
  input  logic       phy_rx_val,
  // receive host side
  output byte_t      rx_dat,
  output logic       rx_val,
  output logic       rx_sof,
  output logic       rx_eof,
  output logic       rx_err,
  output mac_addr_t  rx_dst,
  output mac_addr_t  rx_src,
  output ethertype_t rx_type,
  output frame_len_t rx_len
);

  byte_t      fifo_dat;
  logic       fifo_empty;
  logic       fifo_rd;
  logic       cnt_load;
  frame_len_t cnt_len;
  logic       cnt_step;
  logic       cnt_pay_clr;
  logic       cnt_last;
  logic       cnt_min_done;
  logic       tx_crc_clr;
  logic       tx_crc_en;
  byte_t      tx_crc_dat;
  crc_t       tx_crc;
  logic       rx_crc_clr;
  logic       rx_crc_en;
  logic       rx_crc_ok;

  tx_fifo u_tx_fifo (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .wr_dat  (tx_wr_dat),
    .wr      (tx_wr),
    .rd      (fifo_rd),
    .rd_dat  (fifo_dat),
    .empty   (fifo_empty),
    .full    (tx_full)
  );

  tx_byte_counter u_tx_cnt (
    .clk      (clk),
    .fsm_rst  (fsm_rst),
    .load     (cnt_load),
    .load_len (cnt_len),
    .step     (cnt_step),
    .pay_clr  (cnt_pay_clr),
    .last     (cnt_last),
    .min_done (cnt_min_done)
  );

  tx_framer_fsm u_tx_framer (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .avl          (tx_avl),
    .dst          (tx_dst),
    .ethertype    (tx_type),
    .src          (dev_mac_addr),
    .fifo_dat     (fifo_dat),
    .fifo_empty   (fifo_empty),
    .cnt_last     (cnt_last),
    .cnt_min_done (cnt_min_done),
    .crc          (tx_crc),
    .fifo_rd      (fifo_rd),
    .cnt_load     (cnt_load),
    .cnt_len      (cnt_len),
    .cnt_step     (cnt_step),
    .cnt_pay_clr  (cnt_pay_clr),
    .crc_clr      (tx_crc_clr),
    .crc_en       (tx_crc_en),
    .crc_dat      (tx_crc_dat),
    .phy_dat      (phy_tx_dat),
    .phy_val      (phy_tx_val),
    .busy         (tx_busy),
    .done         (tx_done)
  );

  crc32 crc_tx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (tx_crc_clr),
    .dat     (tx_crc_dat),
    .en      (tx_crc_en),
    .crc     (tx_crc),
    .ok      ()
  );

  // receive crc sees the raw phy bytes, fcs included
  crc32 crc_rx (
    .clk     (clk),
    .fsm_rst (fsm_rst),
    .clr     (rx_crc_clr),
    .dat     (phy_rx_dat),
    .en      (rx_crc_en),
    .crc     (),
    .ok      (rx_crc_ok)
  );

  rx_parser u_rx_parser (
    .clk       (clk),
    .fsm_rst   (fsm_rst),
    .phy_dat   (phy_rx_dat),
    .phy_val   (phy_rx_val),
    .crc_ok    (rx_crc_ok),
    .crc_clr   (rx_crc_clr),
    .crc_en    (rx_crc_en),
    .dat       (rx_dat),
    .val       (rx_val),
    .sof       (rx_sof),
    .eof       (rx_eof),
    .err       (rx_err),
    .dst       (rx_dst),
    .src       (rx_src),
    .ethertype (rx_type),
    .len       (rx_len)
  );

endmodule

/* tests/mac_tb_frames.svh */
`ifndef MAC_TB_FRAMES_SVH
`define MAC_TB_FRAMES_SVH

// n random bytes into the fifo, only the first 64 can stick
task automatic load_payload(input int n);
  byte_t d;
  @(posedge clk);
  for (int i = 0; i < 128; i++) begin
    exp_pay[i] <= 8'h00;
  end
  for (int i = 0; i < n; i++) begin
    d = 8'($urandom);
    @(posedge clk);
    tx_wr     <= 1'b1;
    tx_wr_dat <= d;
    if (i < FIFO_DEPTH) begin
      exp_pay[i] <= d;
    end else begin
      expect_full <= 1'b1;  // 64 bytes already taken
    end
  end
  @(posedge clk);
  tx_wr       <= 1'b0;
  expect_full <= 1'b0;
endtask

task automatic wait_for_tx_done(input int limit);
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!tx_done && n < limit);
  if (!tx_done) abort_run("tx_done never came from the transmit framer");
endtask

task automatic wait_for_rx_end(input int limit);
  int n;
  n = 0;
  do begin
    @(negedge clk);
    n++;
  end while (!(rx_eof || rx_err) && n < limit);
  if (!(rx_eof || rx_err)) abort_run("receive side ended the frame with neither eof nor err");
endtask

// one full frame through the loopback, optionally with a flipped byte
task automatic send_frame(input int n, input logic corrupt);
  int kept;
  int padded;
  kept   = (n < FIFO_DEPTH) ? n : FIFO_DEPTH;
  padded = (kept < MIN_PAYLOAD) ? MIN_PAYLOAD : kept;
  load_payload(n);
  @(posedge clk);
  tx_dst     <= {16'($urandom), $urandom};
  tx_type    <= 16'($urandom);
  exp_len    <= frame_len_t'(padded);
  exp_frame  <= 8'(PREAMBLE_LEN + 1 + HDR_LEN + padded + FCS_LEN);
  expect_err <= corrupt;
  flip_on    <= corrupt;
  if (corrupt) begin
    exp_pay[FLIP_BYTE] <= exp_pay[FLIP_BYTE] ^ 8'h01;
  end
  @(posedge clk);
  tx_avl <= 1'b1;
  wait_for_tx_done(TX_TIMEOUT);
  @(posedge clk);
  tx_avl <= 1'b0;
  wait_for_rx_end(RX_TIMEOUT);
  repeat (4) @(posedge clk);
  flip_on <= 1'b0;
endtask

`endif

/* tests/mac_tb.sv */
`timescale 1ns/1ps

module mac_tb
  import mac_pkg::*;
();

  localparam int        SEED       = 32'h5cb1f7b7;
  localparam int        FIFO_DEPTH = 2 ** FIFO_AW;
  localparam int        FLIP_BYTE  = 5;  // payload byte hit by the loopback flip
  localparam logic[7:0] FLIP_POS   = 8'(PREAMBLE_LEN + 1 + HDR_LEN + FLIP_BYTE);
  localparam int        TX_TIMEOUT = 200;
  localparam int        RX_TIMEOUT = 50;
  localparam mac_addr_t DEV_ADDR   = 48'h02_00_5e_10_20_30;

  logic       clk = 1'b0;
  logic       fsm_rst;
  mac_addr_t  dev_mac_addr;
  byte_t      tx_wr_dat;
  logic       tx_wr;
  logic       tx_avl;
  mac_addr_t  tx_dst;
  ethertype_t tx_type;
  logic       tx_full;
  logic       tx_busy;
  logic       tx_done;
  byte_t      phy_tx_dat;
  logic       phy_tx_val;
  byte_t      phy_rx_dat;
  logic       phy_rx_val;
  byte_t      rx_dat;
  logic       rx_val;
  logic       rx_sof;
  logic       rx_eof;
  logic       rx_err;
  mac_addr_t  rx_dst;
  mac_addr_t  rx_src;
  ethertype_t rx_type;
  frame_len_t rx_len;

  // expected frame, set up before each frame starts
  byte_t      exp_pay [128];
  frame_len_t exp_len;
  logic [7:0] exp_frame;    // phy_tx_val cycles incl. preamble and fcs
  logic       expect_err;
  logic       expect_full;
  logic       flip_on;
  logic       rst_check;

  logic [7:0] tx_idx;       // bytes of the current frame already on the phy
  logic [6:0] rx_idx;
  logic [6:0] pay_pos;
  byte_t      exp_byte;
  logic [1:0] done_cnt;

  int err_cnt;
  int errs_before;
  int test_cnt;
  int test_fail;

  always #4 clk = ~clk;

  // loopback, one byte optionally flipped
  assign phy_rx_dat = phy_tx_dat ^ ((flip_on && tx_idx == FLIP_POS) ? 8'h01 : 8'h00);
  assign phy_rx_val = phy_tx_val;

  assign pay_pos  = rx_sof ? 7'd0 : rx_idx;
  assign exp_byte = exp_pay[pay_pos];

  mac_top dut0 (
    .clk          (clk),
    .fsm_rst      (fsm_rst),
    .dev_mac_addr (dev_mac_addr),
    .tx_wr_dat    (tx_wr_dat),
    .tx_wr        (tx_wr),
    .tx_avl       (tx_avl),
    .tx_dst       (tx_dst),
    .tx_type      (tx_type),
    .tx_full      (tx_full),
    .tx_busy      (tx_busy),
    .tx_done      (tx_done),
    .phy_tx_dat   (phy_tx_dat),
    .phy_tx_val   (phy_tx_val),
    .phy_rx_dat   (phy_rx_dat),
    .phy_rx_val   (phy_rx_val),
    .rx_dat       (rx_dat),
    .rx_val       (rx_val),
    .rx_sof       (rx_sof),
    .rx_eof       (rx_eof),
    .rx_err       (rx_err),
    .rx_dst       (rx_dst),
    .rx_src       (rx_src),
    .rx_type      (rx_type),
    .rx_len       (rx_len)
  );

  always @(posedge clk) begin
    if (fsm_rst) begin
      tx_idx   <= 8'd0;
      rx_idx   <= 7'd0;
      done_cnt <= 2'd0;
    end else begin
      tx_idx <= phy_tx_val ? tx_idx + 8'd1 : 8'd0;
      if (rx_val) begin
        rx_idx <= rx_sof ? 7'd1 : rx_idx + 7'd1;
      end
      if (phy_tx_val && tx_idx == 8'd0) begin
        done_cnt <= 2'd0;  // new frame on the phy
      end else if (tx_done) begin
        done_cnt <= done_cnt + 2'd1;
      end
    end
  end

  task automatic report_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
    $display("ERR t=%0t %s got %0h exp %0h", $time, name, got, exp);
    err_cnt++;
  endtask

  task automatic report_event(input string what);
    $display("error at t=%0t: %s", $time, what);
    err_cnt++;
  endtask

  task automatic abort_run(input string what);
    $display("timeout at t=%0t: %s", $time, what);
    $display("*** FAILED ***");
    $finish;
  endtask

  task automatic finish_test(input string name);
    test_cnt++;
    if (err_cnt != errs_before) begin
      test_fail++;
      $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
    end else begin
      $display("test %0d %s: ok", test_cnt, name);
    end
    errs_before = err_cnt;
  endtask

  `include "mac_tb_frames.svh"

  a_rst_quiet: assert property (@(posedge clk)
    rst_check |-> !(tx_busy || tx_done || phy_tx_val || rx_val || rx_sof || rx_eof || rx_err))
    else report_event("a control output is high right after reset");

  a_rx_dst: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_sof |-> rx_dst == tx_dst)
    else report_value("rx_dst", 64'($sampled(rx_dst)), 64'($sampled(tx_dst)));

  a_rx_src: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_sof |-> rx_src == dev_mac_addr)
    else report_value("rx_src", 64'($sampled(rx_src)), 64'($sampled(dev_mac_addr)));

  a_rx_type: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_sof |-> rx_type == tx_type)
    else report_value("rx_type", 64'($sampled(rx_type)), 64'($sampled(tx_type)));

  // pad bytes are zero in exp_pay
  a_rx_dat: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_val |-> rx_dat == exp_byte)
    else report_value("rx_dat", 64'($sampled(rx_dat)), 64'($sampled(exp_byte)));

  a_rx_len: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_eof |-> rx_len == exp_len)
    else report_value("rx_len", 64'($sampled(rx_len)), 64'($sampled(exp_len)));

  a_no_err: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_err |-> expect_err)
    else report_event("rx_err pulsed on a frame with a good FCS");

  a_no_eof: assert property (@(posedge clk) disable iff (fsm_rst)
    rx_eof |-> !expect_err)
    else report_event("rx_eof pulsed on a frame with a corrupted byte");

  a_preamble: assert property (@(posedge clk) disable iff (fsm_rst)
    phy_tx_val && tx_idx < 8'(PREAMBLE_LEN) |-> phy_tx_dat == PREAMBLE_BYTE)
    else report_value("phy_tx_dat", 64'($sampled(phy_tx_dat)), 64'(PREAMBLE_BYTE));

  a_sfd: assert property (@(posedge clk) disable iff (fsm_rst)
    phy_tx_val && tx_idx == 8'(PREAMBLE_LEN) |-> phy_tx_dat == SFD_BYTE)
    else report_value("phy_tx_dat", 64'($sampled(phy_tx_dat)), 64'(SFD_BYTE));

  a_frame_len: assert property (@(posedge clk) disable iff (fsm_rst)
    !phy_tx_val && tx_idx != 8'd0 |-> tx_idx == exp_frame)
    else report_value("phy_tx_val cycles", 64'($sampled(tx_idx)), 64'($sampled(exp_frame)));

  a_done_slot: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_done |-> !phy_tx_val && tx_idx != 8'd0)
    else report_event("tx_done is not in the cycle after the last FCS byte");

  a_done_once: assert property (@(posedge clk) disable iff (fsm_rst)
    tx_done |-> done_cnt == 2'd0)
    else report_event("tx_done pulsed more than once for one frame");

  a_busy: assert property (@(posedge clk) disable iff (fsm_rst)
    phy_tx_val |-> tx_busy)
    else report_event("tx_busy is low while the frame is on the PHY");

  a_full: assert property (@(posedge clk) disable iff (fsm_rst)
    expect_full |-> tx_full)
    else report_event("tx_full stayed low with 64 bytes in the FIFO");

  initial begin
    fsm_rst      <= 1'b1;
    dev_mac_addr <= DEV_ADDR;
    tx_wr_dat    <= 8'h00;
    tx_wr        <= 1'b0;
    tx_avl       <= 1'b0;
    tx_dst       <= '0;
    tx_type      <= '0;
    exp_len      <= '0;
    exp_frame    <= 8'd0;
    expect_err   <= 1'b0;
    expect_full  <= 1'b0;
    flip_on      <= 1'b0;
    rst_check    <= 1'b0;
    err_cnt      = 0;
    errs_before  = 0;
    test_cnt     = 0;
    test_fail    = 0;
    void'($urandom(SEED));

    repeat (5) @(posedge clk);
    fsm_rst   <= 1'b0;
    rst_check <= 1'b1;
    repeat (3) @(posedge clk);
    rst_check <= 1'b0;
    finish_test("reset state");

    send_frame(60, 1'b0);
    finish_test("header round trip");
    send_frame(52, 1'b0);
    finish_test("payload integrity");
    send_frame(10, 1'b0);
    finish_test("padding");
    send_frame(MIN_PAYLOAD, 1'b0);
    finish_test("transmit framing");
    send_frame(60, 1'b1);
    finish_test("fcs error detection");
    send_frame(FIFO_DEPTH + 1, 1'b0);  // last write is dropped
    finish_test("fifo limit");

    $display("tests run %0d, tests failed %0d, errors %0d", test_cnt, test_fail, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+tests
rtl/mac_pkg.sv
rtl/crc32.sv
rtl/tx_fifo.sv
rtl/tx_byte_counter.sv
rtl/tx_framer_fsm.sv
rtl/rx_parser.sv
rtl/mac_top.sv
tests/mac_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the mac testbench with verilator, run it, and check the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log \
  && verilator --binary --timing --assert --top-module mac_tb -f sources.f -o mac_sim \
  && ./obj_dir/mac_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -qF '*** PASSED ***' sim.log && echo "result: pass" || { echo "result: fail"; exit 1; }
